/* design/controller_config.svh */
// Build-time sizing for the two-wire controller subsystem
// Queue depths and SCL pacing, shared by the RTL and the testbench

`ifndef CONTROLLER_CONFIG_SVH
`define CONTROLLER_CONFIG_SVH

// Queue depths in entries
`define CTRL_CMD_DEPTH 4
`define CTRL_RESP_DEPTH 4
`define CTRL_RX_DEPTH 4

// Clock cycles per SCL level
`define CTRL_SCL_HALF 4

`endif

/* design/controller_pkg.sv */
// Payload and select types for the two-wire controller subsystem
// Referenced by scoped name from the queues, engines and top level

package controller_pkg;

    // One write command: target address plus one data byte
    typedef struct packed {
        logic [6:0] addr;
        logic [7:0] data;
    } cmd_t;

    typedef enum logic [1:0] {
        RESP_OK        = 2'd0,
        RESP_ADDR_NACK = 2'd1,
        RESP_DATA_NACK = 2'd2
    } resp_status_e;

    // Outcome of one command, address echoed back
    typedef struct packed {
        resp_status_e status;
        logic [6:0]   addr;
    } resp_t;

    typedef logic [7:0] byte_t;

    // Pin ownership select, the I3C codes release the pins
    typedef enum logic [1:0] {
        PHY_SEL_ACTIVE      = 2'd0,
        PHY_SEL_I3C_ACTIVE  = 2'd1,
        PHY_SEL_STANDBY     = 2'd2,
        PHY_SEL_I3C_STANDBY = 2'd3
    } phy_sel_e;

endpackage

/* design/sync_fifo.sv */
// First-word-fall-through queue with a type parameter for the payload
// rdata_o shows the oldest entry whenever valid_o is high

`timescale 1ns/1ps

module sync_fifo #(
    parameter type T = logic [7:0],
    parameter int unsigned DEPTH = 4
) (
    input  logic clk_i,
    input  logic reset_i,
    input  logic push_i,
    input  T     wdata_i,
    output logic full_o,
    input  logic pop_i,
    output logic valid_o,
    output T     rdata_o
);

    localparam int unsigned AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int unsigned CW = $clog2(DEPTH + 1);

    T              mem_q [DEPTH];
    logic [AW-1:0] wr_ptr_q;
    logic [AW-1:0] rd_ptr_q;
    logic [CW-1:0] count_q;

    // Wrap at DEPTH so non power of two depths work
    function automatic logic [AW-1:0] ptr_next(input logic [AW-1:0] ptr);
        return (ptr == AW'(DEPTH - 1)) ? '0 : ptr + AW'(1);
    endfunction

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= ptr_next(wr_ptr_q);
            end
            if (pop_i) begin
                rd_ptr_q <= ptr_next(rd_ptr_q);
            end
            case ({push_i, pop_i})
                2'b10:   count_q <= count_q + CW'(1);
                2'b01:   count_q <= count_q - CW'(1);
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (push_i) begin
            mem_q[wr_ptr_q] <= wdata_i;
        end
    end

    assign full_o  = (count_q == CW'(DEPTH));
    assign valid_o = (count_q != '0);
    assign rdata_o = mem_q[rd_ptr_q];

endmodule

/* design/controller_active.sv */
// Bus master engine: pops one write command at a time and runs
// start, address+W, ack, data, ack, stop on the open-drain pins.
// One response is pushed per command with the transfer outcome.

`timescale 1ns/1ps
`include "controller_config.svh"

module controller_active (
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  logic                  en_i,
    input  logic                  cmd_valid_i,
    input  controller_pkg::cmd_t  cmd_data_i,
    output logic                  cmd_pop_o,
    input  logic                  resp_full_i,
    output logic                  resp_push_o,
    output controller_pkg::resp_t resp_data_o,
    input  logic                  scl_i,
    input  logic                  sda_i,
    output logic                  scl_o,
    output logic                  sda_o,
    output logic                  idle_o
);

    localparam int unsigned HALF = `CTRL_SCL_HALF;
    localparam int unsigned CW   = (HALF > 1) ? $clog2(HALF) : 1;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_START,
        ST_BIT,
        ST_ACK,
        ST_STOP,
        ST_RESP
    } state_e;

    state_e                       state_q;
    logic [CW-1:0]                cnt_q;
    logic [2:0]                   bit_cnt_q;
    logic [7:0]                   shift_q;
    logic [6:0]                   addr_q;
    logic [7:0]                   data_q;
    logic                         data_phase_q;
    logic                         ack_q;
    logic                         scl_q;
    logic                         sda_q;
    controller_pkg::resp_status_e status_q;
    logic                         go;
    logic                         tick;
    logic                         mid;
    logic                         start_seen;

    assign go   = (state_q == ST_IDLE) && en_i && cmd_valid_i && !resp_full_i;
    assign tick = (cnt_q == '0);
    assign mid  = (cnt_q == CW'(HALF / 2));

    // Pins must show our start before the count runs
    assign start_seen = scl_i && !sda_i;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            cnt_q <= CW'(HALF - 1);
        end else if (state_q == ST_IDLE || tick) begin
            cnt_q <= CW'(HALF - 1);
        end else if (state_q == ST_START && !start_seen) begin
            cnt_q <= CW'(HALF - 1);
        end else begin
            cnt_q <= cnt_q - CW'(1);
        end
    end

    // scl_q doubles as the phase flag while a frame is running
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q      <= ST_IDLE;
            scl_q        <= 1'b1;
            sda_q        <= 1'b1;
            bit_cnt_q    <= '0;
            data_phase_q <= 1'b0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (go) begin
                        sda_q   <= 1'b0;
                        state_q <= ST_START;
                    end
                end
                ST_START: begin
                    if (tick) begin
                        scl_q        <= 1'b0;
                        bit_cnt_q    <= '0;
                        data_phase_q <= 1'b0;
                        state_q      <= ST_BIT;
                    end
                end
                ST_BIT: begin
                    if (!scl_q && mid) begin
                        sda_q <= shift_q[7];
                    end
                    if (tick) begin
                        scl_q <= !scl_q;
                        if (scl_q) begin
                            bit_cnt_q <= bit_cnt_q + 3'd1;
                            if (bit_cnt_q == 3'd7) begin
                                state_q <= ST_ACK;
                            end
                        end
                    end
                end
                ST_ACK: begin
                    if (!scl_q && mid) begin
                        sda_q <= 1'b1;
                    end
                    if (tick) begin
                        scl_q <= !scl_q;
                        if (scl_q) begin
                            // Address NACK skips the data byte
                            if (ack_q && !data_phase_q) begin
                                data_phase_q <= 1'b1;
                                bit_cnt_q    <= '0;
                                state_q      <= ST_BIT;
                            end else begin
                                state_q <= ST_STOP;
                            end
                        end
                    end
                end
                ST_STOP: begin
                    // SDA low during SCL low, then rises while SCL is high
                    if (mid) begin
                        sda_q <= scl_q;
                    end
                    if (tick) begin
                        if (scl_q) begin
                            state_q <= ST_RESP;
                        end else begin
                            scl_q <= 1'b1;
                        end
                    end
                end
                ST_RESP: begin
                    state_q <= ST_IDLE;
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (go) begin
            addr_q  <= cmd_data_i.addr;
            data_q  <= cmd_data_i.data;
            shift_q <= {cmd_data_i.addr, 1'b0};
        end else if (state_q == ST_BIT && scl_q && tick) begin
            shift_q <= {shift_q[6:0], 1'b0};
        end else if (state_q == ST_ACK && scl_q && tick) begin
            shift_q <= data_q;
        end
        // Ack sampled in the middle of SCL high
        if (state_q == ST_ACK && scl_q && mid) begin
            ack_q <= !sda_i;
        end
        if (state_q == ST_ACK && scl_q && tick) begin
            if (ack_q) begin
                status_q <= controller_pkg::RESP_OK;
            end else if (data_phase_q) begin
                status_q <= controller_pkg::RESP_DATA_NACK;
            end else begin
                status_q <= controller_pkg::RESP_ADDR_NACK;
            end
        end
    end

    assign cmd_pop_o   = go;
    assign resp_push_o = (state_q == ST_RESP);
    assign resp_data_o = {status_q, addr_q};
    assign scl_o       = scl_q;
    assign sda_o       = sda_q;
    assign idle_o      = (state_q == ST_IDLE);

endmodule

/* design/controller_standby.sv */
// Bus target engine: follows start/stop on the pins, acks its own
// write address and stores each received data byte in the rx queue.
// A byte that arrives while the queue is full is NACKed and dropped.

`timescale 1ns/1ps

module controller_standby (
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  logic                  en_i,
    input  logic [6:0]            own_addr_i,
    input  logic                  rx_full_i,
    output logic                  rx_push_o,
    output controller_pkg::byte_t rx_data_o,
    input  logic                  scl_i,
    input  logic                  sda_i,
    output logic                  scl_o,
    output logic                  sda_o
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_ADDR,
        ST_ADDR_ACK,
        ST_DATA,
        ST_DATA_ACK
    } state_e;

    state_e     state_q;
    logic [1:0] scl_sync_q;
    logic [1:0] sda_sync_q;
    logic       scl_prev_q;
    logic       sda_prev_q;
    logic       scl_s;
    logic       sda_s;
    logic       start_det;
    logic       stop_det;
    logic       scl_rise;
    logic       scl_fall;
    logic [3:0] bit_cnt_q;
    logic [7:0] shift_q;
    logic       ack_q;
    logic       sda_q;
    logic       addr_match;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            scl_sync_q <= 2'b11;
            sda_sync_q <= 2'b11;
            scl_prev_q <= 1'b1;
            sda_prev_q <= 1'b1;
        end else begin
            scl_sync_q <= {scl_sync_q[0], scl_i};
            sda_sync_q <= {sda_sync_q[0], sda_i};
            scl_prev_q <= scl_sync_q[1];
            sda_prev_q <= sda_sync_q[1];
        end
    end

    assign scl_s     = scl_sync_q[1];
    assign sda_s     = sda_sync_q[1];
    assign scl_rise  = scl_s && !scl_prev_q;
    assign scl_fall  = !scl_s && scl_prev_q;
    assign start_det = scl_s && scl_prev_q && sda_prev_q && !sda_s;
    assign stop_det  = scl_s && scl_prev_q && !sda_prev_q && sda_s;

    // Write to our address only
    assign addr_match = en_i && (shift_q[7:1] == own_addr_i) && !shift_q[0];

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q   <= ST_IDLE;
            bit_cnt_q <= '0;
            ack_q     <= 1'b0;
            sda_q     <= 1'b1;
        end else if (start_det) begin
            state_q   <= ST_ADDR;
            bit_cnt_q <= '0;
            sda_q     <= 1'b1;
        end else if (stop_det) begin
            state_q <= ST_IDLE;
            sda_q   <= 1'b1;
        end else begin
            case (state_q)
                ST_ADDR, ST_DATA: begin
                    if (scl_rise) begin
                        bit_cnt_q <= bit_cnt_q + 4'd1;
                    end
                    // 8th fall, drive the ack bit
                    if (scl_fall && bit_cnt_q == 4'd8) begin
                        if (state_q == ST_DATA) begin
                            ack_q   <= !rx_full_i;
                            sda_q   <= rx_full_i;
                            state_q <= ST_DATA_ACK;
                        end else if (addr_match) begin
                            sda_q   <= 1'b0;
                            state_q <= ST_ADDR_ACK;
                        end else begin
                            state_q <= ST_IDLE;
                        end
                    end
                end
                ST_ADDR_ACK: begin
                    if (scl_fall) begin
                        sda_q     <= 1'b1;
                        bit_cnt_q <= '0;
                        state_q   <= ST_DATA;
                    end
                end
                ST_DATA_ACK: begin
                    if (scl_fall) begin
                        sda_q     <= 1'b1;
                        bit_cnt_q <= '0;
                        state_q   <= ack_q ? ST_DATA : ST_IDLE;
                    end
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (scl_rise && (state_q == ST_ADDR || state_q == ST_DATA)) begin
            shift_q <= {shift_q[6:0], sda_s};
        end
    end

    assign rx_push_o = (state_q == ST_DATA_ACK) && scl_rise && ack_q;
    assign rx_data_o = shift_q;
    assign scl_o     = 1'b1;
    assign sda_o     = sda_q;

endmodule

/* design/controller.sv */
// Two-wire controller subsystem top: command, response and rx queues,
// the active and standby engines, and the PHY pin multiplexer.
// phy_mux_select_i picks which engine owns the shared SCL/SDA pins.

`timescale 1ns/1ps
`include "controller_config.svh"

module controller (
    input  logic                  clk_i,
    input  logic                  reset_i,

    // Open-drain pins, 1 releases the line
    input  logic                  scl_i,
    input  logic                  sda_i,
    output logic                  scl_o,
    output logic                  sda_o,

    // Configuration
    input  logic [1:0]            phy_mux_select_i,
    input  logic                  active_en_i,
    input  logic                  standby_en_i,
    input  logic [6:0]            target_addr_i,

    // Command queue
    input  logic                  cmd_push_i,
    input  controller_pkg::cmd_t  cmd_data_i,
    output logic                  cmd_full_o,

    // Response queue
    input  logic                  resp_pop_i,
    output logic                  resp_valid_o,
    output controller_pkg::resp_t resp_data_o,

    // Receive queue
    input  logic                  rx_pop_i,
    output logic                  rx_valid_o,
    output controller_pkg::byte_t rx_data_o,

    output logic                  fsm_idle_o
);

    controller_pkg::cmd_t  cmd_rdata;
    controller_pkg::resp_t resp_wdata;
    controller_pkg::byte_t rx_wdata;
    logic                  cmd_valid;
    logic                  cmd_pop;
    logic                  resp_full;
    logic                  resp_push;
    logic                  rx_full;
    logic                  rx_push;
    logic                  act_scl_in;
    logic                  act_sda_in;
    logic                  act_scl_out;
    logic                  act_sda_out;
    logic                  sby_scl_in;
    logic                  sby_sda_in;
    logic                  sby_scl_out;
    logic                  sby_sda_out;

    // Unselected engine sees an idle bus
    always_comb begin : phy_mux
        scl_o      = 1'b1;
        sda_o      = 1'b1;
        act_scl_in = 1'b1;
        act_sda_in = 1'b1;
        sby_scl_in = 1'b1;
        sby_sda_in = 1'b1;
        case (controller_pkg::phy_sel_e'(phy_mux_select_i))
            controller_pkg::PHY_SEL_ACTIVE: begin
                scl_o      = act_scl_out;
                sda_o      = act_sda_out;
                act_scl_in = scl_i;
                act_sda_in = sda_i;
            end
            controller_pkg::PHY_SEL_STANDBY: begin
                scl_o      = sby_scl_out;
                sda_o      = sby_sda_out;
                sby_scl_in = scl_i;
                sby_sda_in = sda_i;
            end
            // I3C codes keep both pins released
            default: begin
                scl_o = 1'b1;
                sda_o = 1'b1;
            end
        endcase
    end

    sync_fifo #(
        .T    (controller_pkg::cmd_t),
        .DEPTH(`CTRL_CMD_DEPTH)
    ) xcmd_fifo (
        .clk_i  (clk_i),
        .reset_i(reset_i),
        .push_i (cmd_push_i),
        .wdata_i(cmd_data_i),
        .full_o (cmd_full_o),
        .pop_i  (cmd_pop),
        .valid_o(cmd_valid),
        .rdata_o(cmd_rdata)
    );

    sync_fifo #(
        .T    (controller_pkg::resp_t),
        .DEPTH(`CTRL_RESP_DEPTH)
    ) xresp_fifo (
        .clk_i  (clk_i),
        .reset_i(reset_i),
        .push_i (resp_push),
        .wdata_i(resp_wdata),
        .full_o (resp_full),
        .pop_i  (resp_pop_i),
        .valid_o(resp_valid_o),
        .rdata_o(resp_data_o)
    );

    sync_fifo #(
        .T    (controller_pkg::byte_t),
        .DEPTH(`CTRL_RX_DEPTH)
    ) xrx_fifo (
        .clk_i  (clk_i),
        .reset_i(reset_i),
        .push_i (rx_push),
        .wdata_i(rx_wdata),
        .full_o (rx_full),
        .pop_i  (rx_pop_i),
        .valid_o(rx_valid_o),
        .rdata_o(rx_data_o)
    );

    controller_active xcontroller_active (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .en_i       (active_en_i),
        .cmd_valid_i(cmd_valid),
        .cmd_data_i (cmd_rdata),
        .cmd_pop_o  (cmd_pop),
        .resp_full_i(resp_full),
        .resp_push_o(resp_push),
        .resp_data_o(resp_wdata),
        .scl_i      (act_scl_in),
        .sda_i      (act_sda_in),
        .scl_o      (act_scl_out),
        .sda_o      (act_sda_out),
        .idle_o     (fsm_idle_o)
    );

    controller_standby xcontroller_standby (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .en_i      (standby_en_i),
        .own_addr_i(target_addr_i),
        .rx_full_i (rx_full),
        .rx_push_o (rx_push),
        .rx_data_o (rx_wdata),
        .scl_i     (sby_scl_in),
        .sda_i     (sby_sda_in),
        .scl_o     (sby_scl_out),
        .sda_o     (sby_sda_out)
    );

endmodule

/* sim/tb_controller.sv */
// Testbench for the two-wire controller subsystem
// A wired-AND bus joins the DUT pins with a target model and a
// bit-banged master model; assertions compare against expected values

`timescale 1ns/1ps
`include "controller_config.svh"

module tb_controller #(
    parameter logic [31:0] SEED = 32'd82475
);

    localparam logic [6:0] TGT_ADDR   = 7'h2A;
    localparam logic [6:0] STBY_ADDR  = 7'h3C;
    localparam logic [6:0] OTHER_ADDR = 7'h15;
    localparam logic [6:0] ALT_ADDR   = 7'h11;
    localparam int         NUM_WR     = 4;
    localparam int         NUM_RX     = 3;
    localparam int         TIMEOUT    = 2000;

    // Target model phases
    localparam logic [1:0] T_IDLE = 2'd0;
    localparam logic [1:0] T_BITS = 2'd1;
    localparam logic [1:0] T_ACK  = 2'd2;
    localparam logic [1:0] T_SKIP = 2'd3;

    logic                  clk_i            = 1'b0;
    logic                  reset_i          = 1'b1;
    logic [1:0]            phy_mux_select_i = controller_pkg::PHY_SEL_ACTIVE;
    logic                  active_en_i      = 1'b0;
    logic                  standby_en_i     = 1'b0;
    logic [6:0]            target_addr_i    = STBY_ADDR;
    logic                  cmd_push_i       = 1'b0;
    controller_pkg::cmd_t  cmd_data_i       = '0;
    logic                  resp_pop_i       = 1'b0;
    logic                  rx_pop_i         = 1'b0;
    logic                  scl_o;
    logic                  sda_o;
    logic                  cmd_full_o;
    logic                  resp_valid_o;
    controller_pkg::resp_t resp_data_o;
    logic                  rx_valid_o;
    controller_pkg::byte_t rx_data_o;
    logic                  fsm_idle_o;

    // Testbench drives on the open-drain bus where 1 releases
    logic scl_drv = 1'b1;
    logic sda_mst = 1'b1;
    logic sda_tgt = 1'b1;
    wire  scl_bus = scl_o & scl_drv;
    wire  sda_bus = sda_o & sda_mst & sda_tgt;

    logic [31:0] rng_state = SEED;

    // Target model state and the frames it decoded
    logic       tgt_en    = 1'b0;
    logic [1:0] tgt_phase = T_IDLE;
    logic       tgt_first = 1'b0;
    logic [3:0] tgt_bits  = '0;
    logic [7:0] tgt_shift = '0;
    logic [7:0] tgt_len   = '0;
    logic       scl_prev  = 1'b1;
    logic       sda_prev  = 1'b1;
    logic [7:0] seen_addr_q [$];
    logic [7:0] seen_data_q [$];
    logic [7:0] frame_len_q [$];

    always #50 clk_i = ~clk_i;

    controller UUT (
        .clk_i           (clk_i),
        .reset_i         (reset_i),
        .scl_i           (scl_bus),
        .sda_i           (sda_bus),
        .scl_o           (scl_o),
        .sda_o           (sda_o),
        .phy_mux_select_i(phy_mux_select_i),
        .active_en_i     (active_en_i),
        .standby_en_i    (standby_en_i),
        .target_addr_i   (target_addr_i),
        .cmd_push_i      (cmd_push_i),
        .cmd_data_i      (cmd_data_i),
        .cmd_full_o      (cmd_full_o),
        .resp_pop_i      (resp_pop_i),
        .resp_valid_o    (resp_valid_o),
        .resp_data_o     (resp_data_o),
        .rx_pop_i        (rx_pop_i),
        .rx_valid_o      (rx_valid_o),
        .rx_data_o       (rx_data_o),
        .fsm_idle_o      (fsm_idle_o)
    );

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("FAILED at %0t ns: %s expected %0h actual %0h", $time, name, expected, actual);
        $display("sim failed");
        $fatal(1, "value mismatch");
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout at %0t ns: %s", $time, what);
        $display("sim failed");
        $fatal(1, "wait timed out");
    endtask

    task automatic check_equal(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else report_mismatch(name, expected, actual);
    endtask

    // Pins stay released whenever an I3C code is selected
    released_in_i3c: assert property (@(posedge clk_i) disable iff (reset_i)
        (phy_mux_select_i == controller_pkg::PHY_SEL_I3C_ACTIVE ||
         phy_mux_select_i == controller_pkg::PHY_SEL_I3C_STANDBY) |-> (scl_o && sda_o))
        else report_mismatch("scl_o & sda_o", 32'd1, 32'(scl_o && sda_o));

    // The target engine never drives SCL
    standby_scl_high: assert property (@(posedge clk_i) disable iff (reset_i)
        (phy_mux_select_i == controller_pkg::PHY_SEL_STANDBY) |-> scl_o)
        else report_mismatch("scl_o", 32'd1, 32'(scl_o));

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic random_byte(output logic [7:0] b);
        rng_state = xorshift32(rng_state);
        b = rng_state[7:0];
    endtask

    // Target model acks TGT_ADDR with write and every data byte
    always @(posedge clk_i) begin
        if (reset_i || !tgt_en) begin
            tgt_phase <= T_IDLE;
            sda_tgt   <= 1'b1;
        end else if (scl_bus && scl_prev && sda_prev && !sda_bus) begin
            tgt_phase <= T_BITS;
            tgt_first <= 1'b1;
            tgt_bits  <= '0;
            tgt_len   <= '0;
            sda_tgt   <= 1'b1;
        end else if (scl_bus && scl_prev && !sda_prev && sda_bus) begin
            if (tgt_phase != T_IDLE) begin
                frame_len_q.push_back(tgt_len);
            end
            tgt_phase <= T_IDLE;
            sda_tgt   <= 1'b1;
        end else if (scl_bus && !scl_prev && tgt_phase == T_BITS) begin
            tgt_shift <= {tgt_shift[6:0], sda_bus};
            tgt_bits  <= tgt_bits + 4'd1;
        end else if (!scl_bus && scl_prev) begin
            if (tgt_phase == T_ACK) begin
                sda_tgt   <= 1'b1;
                tgt_bits  <= '0;
                tgt_phase <= T_BITS;
            end else if (tgt_phase == T_BITS && tgt_bits == 4'd8) begin
                if (tgt_first) begin
                    seen_addr_q.push_back(tgt_shift);
                    tgt_first <= 1'b0;
                    if (tgt_shift == {TGT_ADDR, 1'b0}) begin
                        sda_tgt   <= 1'b0;
                        tgt_phase <= T_ACK;
                    end else begin
                        tgt_phase <= T_SKIP;
                    end
                end else begin
                    seen_data_q.push_back(tgt_shift);
                    tgt_len   <= tgt_len + 8'd1;
                    sda_tgt   <= 1'b0;
                    tgt_phase <= T_ACK;
                end
            end
        end
        scl_prev <= scl_bus;
        sda_prev <= sda_bus;
    end

    task automatic push_command(input logic [6:0] addr, input logic [7:0] data);
        int n;
        n = 0;
        @(negedge clk_i);
        while (cmd_full_o) begin
            if (n == TIMEOUT) begin
                report_timeout("command queue never left full");
            end
            n++;
            @(negedge clk_i);
        end
        @(posedge clk_i);
        cmd_data_i.addr <= addr;
        cmd_data_i.data <= data;
        cmd_push_i      <= 1'b1;
        @(posedge clk_i);
        cmd_push_i <= 1'b0;
    endtask

    task automatic expect_response(input logic [1:0] status, input logic [6:0] addr);
        int n;
        n = 0;
        @(negedge clk_i);
        while (!resp_valid_o) begin
            if (n == TIMEOUT) begin
                report_timeout("no response appeared on resp_valid_o");
            end
            n++;
            @(negedge clk_i);
        end
        check_equal("resp_data_o.status", 32'(status), 32'(resp_data_o.status));
        check_equal("resp_data_o.addr", 32'(addr), 32'(resp_data_o.addr));
        @(posedge clk_i);
        resp_pop_i <= 1'b1;
        @(posedge clk_i);
        resp_pop_i <= 1'b0;
    endtask

    // One decoded frame from the target model with its data byte if any
    task automatic expect_frame(input logic [6:0] addr, input logic [7:0] nbytes,
                                input logic [7:0] data);
        int n;
        n = 0;
        @(negedge clk_i);
        while (frame_len_q.size() == 0) begin
            if (n == TIMEOUT) begin
                report_timeout("target model never saw a stop condition");
            end
            n++;
            @(negedge clk_i);
        end
        check_equal("bus address byte", 32'({addr, 1'b0}), 32'(seen_addr_q.pop_front()));
        check_equal("bus data byte count", 32'(nbytes), 32'(frame_len_q.pop_front()));
        if (nbytes != 8'd0) begin
            check_equal("bus data byte", 32'(data), 32'(seen_data_q.pop_front()));
        end
    endtask

    task automatic expect_rx(input logic [7:0] data);
        int n;
        n = 0;
        @(negedge clk_i);
        while (!rx_valid_o) begin
            if (n == TIMEOUT) begin
                report_timeout("no byte appeared on rx_valid_o");
            end
            n++;
            @(negedge clk_i);
        end
        check_equal("rx_data_o", 32'(data), 32'(rx_data_o));
        @(posedge clk_i);
        rx_pop_i <= 1'b1;
        @(posedge clk_i);
        rx_pop_i <= 1'b0;
    endtask

    // Master model holds every SCL level for 6 cycles
    task automatic send_start();
        @(posedge clk_i);
        sda_mst <= 1'b0;
        repeat (6) @(posedge clk_i);
        scl_drv <= 1'b0;
    endtask

    task automatic send_byte(input logic [7:0] b, input logic ack_expected);
        logic [7:0] sh;
        logic       acked;
        int         i;
        sh = b;
        for (i = 0; i < 8; i++) begin
            repeat (3) @(posedge clk_i);
            sda_mst <= sh[7];
            sh = sh << 1;
            repeat (3) @(posedge clk_i);
            scl_drv <= 1'b1;
            repeat (6) @(posedge clk_i);
            scl_drv <= 1'b0;
        end
        repeat (3) @(posedge clk_i);
        sda_mst <= 1'b1;
        repeat (3) @(posedge clk_i);
        scl_drv <= 1'b1;
        repeat (3) @(posedge clk_i);
        @(negedge clk_i);
        acked = !sda_bus;
        repeat (3) @(posedge clk_i);
        scl_drv <= 1'b0;
        check_equal("sda_bus ack", 32'(ack_expected), 32'(acked));
    endtask

    task automatic send_stop();
        repeat (3) @(posedge clk_i);
        sda_mst <= 1'b0;
        repeat (3) @(posedge clk_i);
        scl_drv <= 1'b1;
        repeat (6) @(posedge clk_i);
        sda_mst <= 1'b1;
        repeat (6) @(posedge clk_i);
    endtask

    initial begin : main_flow
        logic [7:0] sent_q [$];
        logic [7:0] d;
        logic [7:0] d2;
        int         i;

        repeat (2) @(posedge clk_i);
        reset_i <= 1'b0;

        @(negedge clk_i);
        check_equal("scl_o", 32'd1, 32'(scl_o));
        check_equal("sda_o", 32'd1, 32'(sda_o));
        check_equal("resp_valid_o", 32'd0, 32'(resp_valid_o));
        check_equal("rx_valid_o", 32'd0, 32'(rx_valid_o));
        check_equal("fsm_idle_o", 32'd1, 32'(fsm_idle_o));
        check_equal("cmd_full_o", 32'd0, 32'(cmd_full_o));

        // Writes to the acknowledging target
        @(posedge clk_i);
        tgt_en      <= 1'b1;
        active_en_i <= 1'b1;
        for (i = 0; i < NUM_WR; i++) begin
            random_byte(d);
            sent_q.push_back(d);
            push_command(TGT_ADDR, d);
        end
        for (i = 0; i < NUM_WR; i++) begin
            expect_response(controller_pkg::RESP_OK, TGT_ADDR);
            expect_frame(TGT_ADDR, 8'd1, sent_q.pop_front());
        end

        // Address NACK followed by a good write
        random_byte(d);
        random_byte(d2);
        push_command(OTHER_ADDR, d);
        push_command(TGT_ADDR, d2);
        expect_response(controller_pkg::RESP_ADDR_NACK, OTHER_ADDR);
        expect_frame(OTHER_ADDR, 8'd0, 8'd0);
        expect_response(controller_pkg::RESP_OK, TGT_ADDR);
        expect_frame(TGT_ADDR, 8'd1, d2);
        @(negedge clk_i);
        check_equal("fsm_idle_o", 32'd1, 32'(fsm_idle_o));

        // Standby receive from the master model
        @(posedge clk_i);
        active_en_i      <= 1'b0;
        tgt_en           <= 1'b0;
        standby_en_i     <= 1'b1;
        phy_mux_select_i <= controller_pkg::PHY_SEL_STANDBY;
        repeat (4) @(posedge clk_i);
        send_start();
        send_byte({STBY_ADDR, 1'b0}, 1'b1);
        for (i = 0; i < NUM_RX; i++) begin
            random_byte(d);
            sent_q.push_back(d);
            send_byte(d, 1'b1);
        end
        send_stop();
        for (i = 0; i < NUM_RX; i++) begin
            expect_rx(sent_q.pop_front());
        end

        send_start();
        send_byte({ALT_ADDR, 1'b0}, 1'b0);
        send_stop();
        repeat (20) @(posedge clk_i);
        @(negedge clk_i);
        check_equal("rx_valid_o", 32'd0, 32'(rx_valid_o));

        // One byte more than the rx queue holds
        send_start();
        send_byte({STBY_ADDR, 1'b0}, 1'b1);
        for (i = 0; i <= `CTRL_RX_DEPTH; i++) begin
            random_byte(d);
            sent_q.push_back(d);
            send_byte(d, i < `CTRL_RX_DEPTH);
        end
        send_stop();
        for (i = 0; i < `CTRL_RX_DEPTH; i++) begin
            expect_rx(sent_q.pop_front());
        end
        @(negedge clk_i);
        check_equal("rx_valid_o", 32'd0, 32'(rx_valid_o));

        // I3C code holds the command off the pins
        @(posedge clk_i);
        standby_en_i     <= 1'b0;
        tgt_en           <= 1'b1;
        active_en_i      <= 1'b1;
        phy_mux_select_i <= controller_pkg::PHY_SEL_I3C_ACTIVE;
        random_byte(d);
        push_command(TGT_ADDR, d);
        for (i = 0; i < 300; i++) begin
            @(negedge clk_i);
            check_equal("resp_valid_o", 32'd0, 32'(resp_valid_o));
            check_equal("scl_o", 32'd1, 32'(scl_o));
            check_equal("sda_o", 32'd1, 32'(sda_o));
        end
        // Command was popped and its response is still pending
        check_equal("fsm_idle_o", 32'd0, 32'(fsm_idle_o));
        @(posedge clk_i);
        phy_mux_select_i <= controller_pkg::PHY_SEL_ACTIVE;
        expect_response(controller_pkg::RESP_OK, TGT_ADDR);
        expect_frame(TGT_ADDR, 8'd1, d);

        $display("sim passed");
        $finish;
    end

endmodule

/* compile.f */
+incdir+design
design/controller_pkg.sv
design/sync_fifo.sv
design/controller_active.sv
design/controller_standby.sv
design/controller.sv
sim/tb_controller.sv

/* Makefile */
# Verilator build and run for the two-wire controller testbench
# Override any variable on the command line, e.g. make sim SEED=1234

VERILATOR ?= verilator
TOP       ?= tb_controller
SEED      ?= 82475
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

# The binary exits non-zero on $fatal, so make fails with the test
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -GSEED=$(SEED) \
		-f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
